// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --assert --timing -j 0
TOP       = dxa_tb
FILELIST  = dxa_subsystem.f
RTL_TOP   = dxa_subsystem

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== dxa_subsystem.f ====
src/dxa_pkg.sv
src/dxa_rsp_buffer.sv
src/dxa_issue_unit.sv
src/dxa_cfg_regs.sv
src/dxa_engine.sv
src/dxa_barrier_table.sv
src/dxa_subsystem.sv
tb/dxa_asserts.sv
tb/dxa_tb.sv

// ==== src/dxa_barrier_table.sv ====
/*
 * Pending-bit table for transfer barriers, one bit per {warp, barrier}.
 * A setup to an entry that is already pending is refused until a done
 * clears it. A done is always accepted, even for an idle entry.
 */
`timescale 1ns/1ns

module dxa_barrier_table import dxa_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       bar_valid,
    output logic                       bar_ready,
    input  logic [BAR_ADDR_W-1:0]      bar_addr,
    input  logic                       bar_is_done,
    output logic [NUM_BAR_ENTRIES-1:0] bar_pending
);

    logic bar_fire;

    assign bar_ready = bar_is_done || !bar_pending[bar_addr];
    assign bar_fire  = bar_valid && bar_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            bar_pending <= '0;
        end else if (bar_fire) begin
            // Done clears, setup arms
            bar_pending[bar_addr] <= !bar_is_done;
        end
    end

endmodule

// ==== src/dxa_cfg_regs.sv ====
/*
 * Transfer descriptor registers.
 * Setup0 writes the source and barrier, setup1 the destination and the
 * length from the low bits of rs2. Other opcodes leave them unchanged.
 */
`timescale 1ns/1ns

module dxa_cfg_regs import dxa_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  dxa_op_t               wr_op,
    input  logic [XLEN-1:0]       wr_rs1,
    input  logic [XLEN-1:0]       wr_rs2,
    output logic [XLEN-1:0]       src_addr,
    output logic [XLEN-1:0]       dst_addr,
    output logic [LEN_W-1:0]      xfer_len,
    output logic [BAR_ADDR_W-1:0] bar_addr
);

    always_ff @(posedge clk) begin
        if (rst) begin
            src_addr <= '0;
            dst_addr <= '0;
            xfer_len <= '0;
            bar_addr <= '0;
        end else if (wr_en) begin
            if (wr_op == DXA_OP_SETUP0) begin
                src_addr <= wr_rs1;
                bar_addr <= bar_addr_of(wr_rs2);
            end else if (wr_op == DXA_OP_SETUP1) begin
                dst_addr <= wr_rs1;
                xfer_len <= wr_rs2[LEN_W-1:0];
            end
        end
    end

endmodule

// ==== src/dxa_engine.sv ====
/*
 * Cluster-level transfer engine.
 * Only one transfer runs at a time: requests are taken in ENG_IDLE only.
 * The descriptor is sampled at start, so a later setup does not disturb a
 * walk in progress. Each word is one address pair, no data moves.
 */
`timescale 1ns/1ns

module dxa_engine import dxa_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  dxa_op_t               req_op,
    input  logic [XLEN-1:0]       req_rs1,
    input  logic [XLEN-1:0]       req_rs2,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output logic [BAR_ADDR_W-1:0] rsp_bar_addr,
    output logic                  rsp_done,
    output logic                  rsp_notify,
    output logic                  xfer_valid,
    input  logic                  xfer_ready,
    output logic [XLEN-1:0]       xfer_src,
    output logic [XLEN-1:0]       xfer_dst
);

    eng_state_t            state;
    logic [XLEN-1:0]       cfg_src;
    logic [XLEN-1:0]       cfg_dst;
    logic [LEN_W-1:0]      cfg_len;
    logic [BAR_ADDR_W-1:0] cfg_bar;
    logic [LEN_W-1:0]      words_left;
    logic                  req_fire;
    logic                  start_fire;
    logic                  xfer_fire;

    assign req_ready  = (state == ENG_IDLE);
    assign req_fire   = req_valid && req_ready;
    assign start_fire = req_fire && (req_op == DXA_OP_START);
    assign xfer_fire  = xfer_valid && xfer_ready;

    assign xfer_valid = (state == ENG_WALK);
    assign rsp_valid  = (state == ENG_RSP);
    // Every response here closes a walk and releases its barrier
    assign rsp_done   = rsp_valid;
    assign rsp_notify = rsp_valid;

    dxa_cfg_regs cfg (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (req_fire),
        .wr_op    (req_op),
        .wr_rs1   (req_rs1),
        .wr_rs2   (req_rs2),
        .src_addr (cfg_src),
        .dst_addr (cfg_dst),
        .xfer_len (cfg_len),
        .bar_addr (cfg_bar)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ENG_IDLE;
        end else begin
            case (state)
                ENG_IDLE: begin
                    if (start_fire) begin
                        // An empty descriptor skips straight to the response
                        state <= (cfg_len == '0) ? ENG_RSP : ENG_WALK;
                    end
                end
                ENG_WALK: begin
                    if (xfer_fire && words_left == LEN_W'(1)) begin
                        state <= ENG_RSP;
                    end
                end
                ENG_RSP: begin
                    if (rsp_ready) begin
                        state <= ENG_IDLE;
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_fire) begin
            xfer_src     <= cfg_src;
            xfer_dst     <= cfg_dst;
            words_left   <= cfg_len;
            rsp_bar_addr <= cfg_bar;
        end else if (xfer_fire) begin
            xfer_src   <= xfer_src + XLEN'(WORD_BYTES);
            xfer_dst   <= xfer_dst + XLEN'(WORD_BYTES);
            words_left <= words_left - LEN_W'(1);
        end
    end

endmodule

// ==== src/dxa_issue_unit.sv ====
/*
 * Core-side issue stage for transfer instructions.
 * Operands are taken from the lowest active lane only; an empty thread
 * mask falls back to lane 0. Every instruction, NOP included, waits for
 * req_ready. Setup0 is also held until its barrier entry is free.
 */
`timescale 1ns/1ns

module dxa_issue_unit import dxa_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      exec_valid,
    output logic                      exec_ready,
    input  logic [UUID_W-1:0]         exec_uuid,
    input  logic [NW_BITS-1:0]        exec_wid,
    input  logic [NUM_LANES-1:0]      exec_tmask,
    input  dxa_op_t                   exec_op,
    input  logic [NUM_LANES*XLEN-1:0] exec_rs1,
    input  logic [NUM_LANES*XLEN-1:0] exec_rs2,
    output logic                      req_valid,
    input  logic                      req_ready,
    output dxa_op_t                   req_op,
    output logic [NW_BITS-1:0]        req_wid,
    output logic [XLEN-1:0]           req_rs1,
    output logic [XLEN-1:0]           req_rs2,
    input  logic                      rsp_valid,
    output logic                      rsp_ready,
    input  logic [BAR_ADDR_W-1:0]     rsp_bar_addr,
    input  logic                      rsp_done,
    input  logic                      rsp_notify,
    output logic                      bar_valid,
    input  logic                      bar_ready,
    output logic [BAR_ADDR_W-1:0]     bar_addr,
    output logic                      bar_is_done,
    output logic                      result_valid,
    input  logic                      result_ready,
    output logic [UUID_W-1:0]         result_uuid,
    output logic [NW_BITS-1:0]        result_wid
);

    logic [LANE_BITS-1:0] lane_sel;
    logic                 buf_ready;
    logic                 is_setup0;
    logic                 bar_ok;
    logic                 setup_go;
    logic                 rsp_notify_valid;
    logic                 rsp_emit;

    // Scanning downwards leaves the lowest set bit as the winner
    always_comb begin
        lane_sel = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (exec_tmask[i]) begin
                lane_sel = LANE_BITS'(i);
            end
        end
    end

    assign req_rs1 = exec_rs1[lane_sel*XLEN +: XLEN];
    assign req_rs2 = exec_rs2[lane_sel*XLEN +: XLEN];
    assign req_op  = exec_op;
    assign req_wid = exec_wid;

    assign is_setup0 = (exec_op == DXA_OP_SETUP0);
    assign bar_ok    = !is_setup0 || bar_ready;

    assign exec_ready = buf_ready && req_ready && bar_ok;
    assign req_valid  = exec_valid && exec_ready && (exec_op != DXA_OP_NOP);

    // The setup candidate selects the table address without depending on
    // bar_ready, which keeps the accept path free of a loop
    assign setup_go         = exec_valid && is_setup0 && buf_ready && req_ready;
    assign rsp_notify_valid = rsp_valid && rsp_notify;
    assign rsp_emit         = rsp_notify_valid && !setup_go;

    assign bar_valid   = setup_go || rsp_emit;
    assign bar_addr    = setup_go ? bar_addr_of(req_rs2) : rsp_bar_addr;
    assign bar_is_done = setup_go ? 1'b0 : rsp_done;

    assign rsp_ready = !rsp_notify_valid || (bar_ready && !setup_go);

    dxa_rsp_buffer rsp_buf (
        .clk           (clk),
        .rst           (rst),
        .valid_in      (exec_valid && req_ready && bar_ok),
        .ready_in      (buf_ready),
        .data_uuid_in  (exec_uuid),
        .data_wid_in   (exec_wid),
        .valid_out     (result_valid),
        .ready_out     (result_ready),
        .data_uuid_out (result_uuid),
        .data_wid_out  (result_wid)
    );

endmodule

// ==== src/dxa_pkg.sv ====
/*
 * Shared constants and types for the data-transfer issue path.
 * Lane, warp and barrier counts are fixed here and cannot be overridden
 * per instance. Barrier addresses are {warp, barrier}, so NUM_BAR_ENTRIES
 * must equal 2**BAR_ADDR_W.
 */
package dxa_pkg;

    localparam int XLEN            = 32;
    localparam int NUM_LANES       = 4;
    localparam int LANE_BITS       = 2;
    localparam int NUM_WARPS       = 4;
    localparam int NW_BITS         = 2;
    localparam int NUM_BARS        = 4;
    localparam int NB_BITS         = 2;
    localparam int BAR_ADDR_W      = NW_BITS + NB_BITS;
    localparam int NUM_BAR_ENTRIES = NUM_WARPS * NUM_BARS;
    localparam int UUID_W          = 8;
    localparam int LEN_W           = 8;
    localparam int WORD_BYTES      = 4;
    localparam int BAR_FIELD_LSB   = 16;

    typedef enum logic [1:0] {
        DXA_OP_SETUP0,
        DXA_OP_SETUP1,
        DXA_OP_START,
        DXA_OP_NOP
    } dxa_op_t;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_WALK,
        ENG_RSP
    } eng_state_t;

    // Warp id sits in the low bits of rs2, the barrier index further up
    function automatic logic [BAR_ADDR_W-1:0] bar_addr_of(input logic [XLEN-1:0] rs2);
        return {rs2[NW_BITS-1:0], rs2[BAR_FIELD_LSB +: NB_BITS]};
    endfunction

endpackage

// ==== src/dxa_rsp_buffer.sv ====
/*
 * Two-entry skid buffer for result headers.
 * The output is registered and ready_in comes straight from a flop, so a
 * push is taken only when the skid slot is empty.
 */
`timescale 1ns/1ns

module dxa_rsp_buffer import dxa_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               valid_in,
    output logic               ready_in,
    input  logic [UUID_W-1:0]  data_uuid_in,
    input  logic [NW_BITS-1:0] data_wid_in,
    output logic               valid_out,
    input  logic               ready_out,
    output logic [UUID_W-1:0]  data_uuid_out,
    output logic [NW_BITS-1:0] data_wid_out
);

    logic               skid_valid;
    logic [UUID_W-1:0]  skid_uuid;
    logic [NW_BITS-1:0] skid_wid;
    logic               push;
    logic               out_free;

    assign ready_in = !skid_valid;
    assign push     = valid_in && ready_in;
    assign out_free = !valid_out || ready_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            valid_out  <= skid_valid || push;
            skid_valid <= 1'b0;
        end else if (push) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            data_uuid_out <= skid_valid ? skid_uuid : data_uuid_in;
            data_wid_out  <= skid_valid ? skid_wid : data_wid_in;
        end else if (push) begin
            skid_uuid <= data_uuid_in;
            skid_wid  <= data_wid_in;
        end
    end

endmodule

// ==== src/dxa_subsystem.sv ====
/*
 * Issue unit, transfer engine and barrier table wired together.
 * The cluster path is always present. The transfer port carries
 * addresses only and the result data is implicitly zero.
 */
`timescale 1ns/1ns

module dxa_subsystem import dxa_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       exec_valid,
    output logic                       exec_ready,
    input  logic [UUID_W-1:0]          exec_uuid,
    input  logic [NW_BITS-1:0]         exec_wid,
    input  logic [NUM_LANES-1:0]       exec_tmask,
    input  dxa_op_t                    exec_op,
    input  logic [NUM_LANES*XLEN-1:0]  exec_rs1,
    input  logic [NUM_LANES*XLEN-1:0]  exec_rs2,
    output logic                       result_valid,
    input  logic                       result_ready,
    output logic [UUID_W-1:0]          result_uuid,
    output logic [NW_BITS-1:0]         result_wid,
    output logic                       xfer_valid,
    input  logic                       xfer_ready,
    output logic [XLEN-1:0]            xfer_src,
    output logic [XLEN-1:0]            xfer_dst,
    output logic [NUM_BAR_ENTRIES-1:0] bar_pending
);

    logic                  req_valid;
    logic                  req_ready;
    dxa_op_t               req_op;
    logic [XLEN-1:0]       req_rs1;
    logic [XLEN-1:0]       req_rs2;
    logic                  rsp_valid;
    logic                  rsp_ready;
    logic [BAR_ADDR_W-1:0] rsp_bar_addr;
    logic                  rsp_done;
    logic                  rsp_notify;
    logic                  bar_valid;
    logic                  bar_ready;
    logic [BAR_ADDR_W-1:0] bar_addr;
    logic                  bar_is_done;

    dxa_issue_unit issue (
        .clk          (clk),
        .rst          (rst),
        .exec_valid   (exec_valid),
        .exec_ready   (exec_ready),
        .exec_uuid    (exec_uuid),
        .exec_wid     (exec_wid),
        .exec_tmask   (exec_tmask),
        .exec_op      (exec_op),
        .exec_rs1     (exec_rs1),
        .exec_rs2     (exec_rs2),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_op       (req_op),
        // Warp tag is kept for later request tagging and has no sink yet
        .req_wid      (),
        .req_rs1      (req_rs1),
        .req_rs2      (req_rs2),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_bar_addr (rsp_bar_addr),
        .rsp_done     (rsp_done),
        .rsp_notify   (rsp_notify),
        .bar_valid    (bar_valid),
        .bar_ready    (bar_ready),
        .bar_addr     (bar_addr),
        .bar_is_done  (bar_is_done),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_uuid  (result_uuid),
        .result_wid   (result_wid)
    );

    dxa_engine engine (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_op       (req_op),
        .req_rs1      (req_rs1),
        .req_rs2      (req_rs2),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_bar_addr (rsp_bar_addr),
        .rsp_done     (rsp_done),
        .rsp_notify   (rsp_notify),
        .xfer_valid   (xfer_valid),
        .xfer_ready   (xfer_ready),
        .xfer_src     (xfer_src),
        .xfer_dst     (xfer_dst)
    );

    dxa_barrier_table bars (
        .clk         (clk),
        .rst         (rst),
        .bar_valid   (bar_valid),
        .bar_ready   (bar_ready),
        .bar_addr    (bar_addr),
        .bar_is_done (bar_is_done),
        .bar_pending (bar_pending)
    );

endmodule

// ==== tb/dxa_asserts.sv ====
/*
 * Handshake and reset checks bound into the subsystem.
 * Stability checks assume the transfer and result ports follow the
 * usual rule that a raised valid is held until accepted.
 */
`timescale 1ns/1ns

module dxa_asserts import dxa_pkg::*; (
    input logic               clk,
    input logic               rst,
    input logic               xfer_valid,
    input logic               xfer_ready,
    input logic [XLEN-1:0]    xfer_src,
    input logic               result_valid,
    input logic               result_ready,
    input logic [UUID_W-1:0]  result_uuid,
    input logic [NW_BITS-1:0] result_wid
);

    a_xfer_hold: assert property (@(posedge clk) disable iff (rst)
        xfer_valid && !xfer_ready |=> xfer_valid && $stable(xfer_src))
        else $error("transfer pair changed while stalled");

    a_result_hold: assert property (@(posedge clk) disable iff (rst)
        result_valid && !result_ready |=>
            result_valid && $stable(result_uuid) && $stable(result_wid))
        else $error("result header changed while stalled");

    // A new pair only appears after the previous one was taken
    a_xfer_single: assert property (@(posedge clk) disable iff (rst)
        xfer_valid && xfer_ready |=>
            !xfer_valid || xfer_src == $past(xfer_src) + XLEN'(WORD_BYTES))
        else $error("transfer pair skipped or repeated");

    a_reset_idle: assert property (@(posedge clk)
        rst |=> !result_valid && !xfer_valid)
        else $error("valid high right after reset");

endmodule

bind dxa_subsystem dxa_asserts chk (.*);

// ==== tb/dxa_stim.txt ====
# op wid uuid tmask rs1_l0 rs1_l1 rs1_l2 rs1_l3 rs2_l0 rs2_l1 rs2_l2 rs2_l3 words pending
# op 0=setup0 1=setup1 2=start 3=nop, all hex except the decimal word count
0 1 01 f 00001000 11111111 22222222 33333333 00010001 00000000 00000000 00000000 0 0020
1 1 02 f 00002000 44444444 55555555 66666666 00000005 00000000 00000000 00000000 0 0020
2 1 03 1 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 5 0000
3 2 04 3 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0 0000
0 3 05 c 0000aaaa 0000bbbb 00003000 0000cccc 00000000 00000000 00020003 00000001 0 4000
1 3 06 a 0000dddd 00004000 0000eeee 0000ffff 00000001 00000008 00000002 00000003 0 4000
2 3 07 8 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 8 0000
0 2 08 2 00000abc 00005000 00000def 00000123 00030003 00000002 00000001 00000000 0 0100
1 2 09 0 00006000 00000777 00000888 00000999 00000000 00000004 00000004 00000004 0 0100
2 2 0a 6 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0 0000
0 1 0b 1 00007000 00000000 00000000 00000000 00010001 00000000 00000000 00000000 0 0020
1 0 0c 4 00000000 00000000 00008000 00000000 00000000 00000000 00000003 00000000 0 0020
2 0 0d f 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3 0000
3 0 0e 0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0 0000

// ==== tb/dxa_tb.sv ====
/*
 * Testbench for the transfer subsystem, driven from tb/dxa_stim.txt.
 * Run from the project root. Each stim line is one instruction; start
 * lines wait for their walk to finish before bar_pending is compared.
 */
`timescale 1ns/1ns

module dxa_tb import dxa_pkg::*; ();

    logic                       clk;
    logic                       rst;
    logic                       exec_valid;
    logic                       exec_ready;
    logic [UUID_W-1:0]          exec_uuid;
    logic [NW_BITS-1:0]         exec_wid;
    logic [NUM_LANES-1:0]       exec_tmask;
    dxa_op_t                    exec_op;
    logic [NUM_LANES*XLEN-1:0]  exec_rs1;
    logic [NUM_LANES*XLEN-1:0]  exec_rs2;
    logic                       result_valid;
    logic                       result_ready;
    logic [UUID_W-1:0]          result_uuid;
    logic [NW_BITS-1:0]         result_wid;
    logic                       xfer_valid;
    logic                       xfer_ready;
    logic [XLEN-1:0]            xfer_src;
    logic [XLEN-1:0]            xfer_dst;
    logic [NUM_BAR_ENTRIES-1:0] bar_pending;

    logic [63:0] line_f [$];
    logic [UUID_W+NW_BITS-1:0] res_q [$];
    logic [2*XLEN-1:0] addr_q [$];
    int errors = 0;
    int passes = 0;
    int cycles = 0;
    int limit = 100000;
    int words_seen = 0;

    dxa_subsystem dut0 (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: transfer did not finish");
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // Operands come from the first active lane, lane 0 when none is
    function automatic int lowest_lane(input logic [NUM_LANES-1:0] mask);
        int lane;
        lane = 0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (mask[i] && lane == 0 && mask[lane] == 1'b0) begin
                lane = i;
            end
        end
        return lane;
    endfunction

    always @(posedge clk) begin
        xfer_ready   <= ($urandom % 4) != 0;
        result_ready <= ($urandom % 3) != 0;
        if (!rst && xfer_valid && xfer_ready) begin
            if (addr_q.size() == 0) begin
                errors++;
                $display("Transfer word seen with no transfer expected");
            end else begin
                check_val("xfer_src", xfer_src, addr_q[0][2*XLEN-1:XLEN]);
                check_val("xfer_dst", xfer_dst, addr_q[0][XLEN-1:0]);
                void'(addr_q.pop_front());
            end
            words_seen <= words_seen + 1;
        end
        if (!rst && result_valid && result_ready) begin
            if (res_q.size() == 0) begin
                errors++;
                $display("Result seen with no accepted instruction");
            end else begin
                check_val("result_uuid", result_uuid, res_q[0][UUID_W+NW_BITS-1:NW_BITS]);
                check_val("result_wid", result_wid, res_q[0][NW_BITS-1:0]);
                void'(res_q.pop_front());
            end
        end
    end

    initial begin
        int fd;
        int n;
        int lane;
        int len_sum;
        int err_before;
        int target;
        int words_before;
        string line;
        logic [63:0] f [14];
        logic [XLEN-1:0] m_src;
        logic [XLEN-1:0] m_dst;
        logic [LEN_W-1:0] m_len;
        logic [BAR_ADDR_W-1:0] m_bar;
        logic [XLEN-1:0] r1;
        logic [XLEN-1:0] r2;

        clk = 0;
        rst = 1;
        exec_valid = 0;
        exec_uuid = '0;
        exec_wid = '0;
        exec_tmask = '0;
        exec_op = DXA_OP_NOP;
        exec_rs1 = '0;
        exec_rs2 = '0;
        xfer_ready = 0;
        result_ready = 0;
        m_src = '0;
        m_dst = '0;
        m_len = '0;
        m_bar = '0;
        len_sum = 0;
        void'($urandom(32'h4fb5));

        fd = $fopen("tb/dxa_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the stim file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 4 || line.getc(0) == 8'h23) begin
                    continue;
                end
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %d %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                            f[8], f[9], f[10], f[11], f[12], f[13]);
                if (n != 14) begin
                    errors++;
                    $display("Stim line could not be parsed: %s", line);
                    continue;
                end
                for (int i = 0; i < 14; i++) begin
                    line_f.push_back(f[i]);
                end
                len_sum += int'(f[12]);
            end
            $fclose(fd);
            limit = 30 * (line_f.size() / 14) + 4 * len_sum;
        end

        repeat (5) @(posedge clk);
        rst <= 0;

        for (int t = 0; t < line_f.size() / 14; t++) begin
            for (int i = 0; i < 14; i++) begin
                f[i] = line_f[t*14 + i];
            end
            err_before = errors;
            @(posedge clk);
            exec_valid <= 1;
            exec_op    <= dxa_op_t'(f[0][1:0]);
            exec_wid   <= f[1][NW_BITS-1:0];
            exec_uuid  <= f[2][UUID_W-1:0];
            exec_tmask <= f[3][NUM_LANES-1:0];
            for (int l = 0; l < NUM_LANES; l++) begin
                exec_rs1[l*XLEN +: XLEN] <= f[4+l][XLEN-1:0];
                exec_rs2[l*XLEN +: XLEN] <= f[8+l][XLEN-1:0];
            end
            do begin
                @(posedge clk);
            end while (!(exec_valid && exec_ready));
            exec_valid <= 0;
            res_q.push_back({f[2][UUID_W-1:0], f[1][NW_BITS-1:0]});

            lane = lowest_lane(f[3][NUM_LANES-1:0]);
            r1 = f[4+lane][XLEN-1:0];
            r2 = f[8+lane][XLEN-1:0];
            case (f[0][1:0])
                2'd0: begin
                    m_src = r1;
                    m_bar = BAR_ADDR_W'((r2 & 3) * NUM_BARS + ((r2 >> 16) & 3));
                    @(posedge clk);
                    check_val("bar_pending[m_bar]", 64'(bar_pending[m_bar]), 64'(1));
                end
                2'd1: begin
                    m_dst = r1;
                    m_len = r2[LEN_W-1:0];
                    @(posedge clk);
                end
                2'd2: begin
                    words_before = words_seen;
                    for (int w = 0; w < m_len; w++) begin
                        addr_q.push_back({m_src + XLEN'(WORD_BYTES * w),
                                          m_dst + XLEN'(WORD_BYTES * w)});
                    end
                    target = words_seen + int'(m_len);
                    wait (words_seen >= target);
                    // Response follows the last word, the clear lands one edge later
                    repeat (2) @(posedge clk);
                    check_val("xfer_words", 64'(words_seen - words_before), f[12]);
                    check_val("bar_pending[m_bar]", 64'(bar_pending[m_bar]), 64'(0));
                end
                default: begin
                    @(posedge clk);
                end
            endcase
            check_val("bar_pending", 64'(bar_pending), f[13]);
            if (errors == err_before) begin
                passes++;
                $display("Test %0d op %0d bar %0h: ok", t, f[0], m_bar);
            end else begin
                $display("Test %0d op %0d bar %0h: FAILED", t, f[0], m_bar);
            end
        end

        while (res_q.size() != 0) begin
            @(posedge clk);
        end
        if (addr_q.size() != 0) begin
            errors++;
            $display("Transfer words still missing at end of run");
        end
        $display("Passed %0d tests, %0d errors", passes, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
